//--- logic/fog_sig_pkg.sv
package fog_sig_pkg;

	// converter and datapath widths
	localparam int ADC_W = 14; // adc sample width
	localparam int DAC_W = 16; // dac word width
	localparam int ACC_W = 32; // half sums, error word and feedback step

	// adc samples are two's complement
	typedef logic signed [ADC_W-1:0] adc_t;
	typedef logic [DAC_W-1:0] dac_t;        // wraps mod 2^16
	typedef logic signed [ACC_W-1:0] err_t; // error, step and sums

	// modulation timing out of mod_gen
	typedef struct packed {
		logic level_high;   // current half uses amp_h
		logic switch_pulse; // first cycle of a new half
	} mod_evt_t;

	// one-cycle error result, once per high/low pair
	typedef struct packed {
		logic valid;
		err_t err;
	} err_evt_t;

	// new feedback step, one cycle after the error
	typedef struct packed {
		logic valid;
		err_t step;
	} step_evt_t;

	// demodulator window inside each half period
	typedef enum logic [1:0] {
		S_SETTLE, // fibre response still ringing, samples dropped
		S_ACCUM,  // inside the averaging window
		S_HOLD    // window done, idle until next switch
	} demod_state_t;

endpackage

//--- logic/fog_cfg_pkg.sv
package fog_cfg_pkg;

	// dac level and signed error types for the fields below
	import fog_sig_pkg::dac_t;
	import fog_sig_pkg::err_t;

	localparam int CFG_W     = 32; // width of every config field
	localparam int AVG_SEL_W = 4;  // log2 of samples per half (max 10)
	localparam int GAIN_W    = 5;  // arithmetic shift amount

	typedef logic [CFG_W-1:0] cfg_word_t;
	typedef logic [GAIN_W-1:0] gain_t;

	// static loop setup only touched while i_rst is high
	typedef struct packed {
		cfg_word_t freq_cnt;  // half period in clocks
		dac_t amp_h;          // level in the even halves
		dac_t amp_l;          // level in the odd halves
		logic polarity;       // 1 flips the sign of the difference
		cfg_word_t wait_cnt;  // samples skipped after each switch
		logic [AVG_SEL_W-1:0] avg_sel; // 2^avg_sel samples averaged
		err_t err_offset;     // subtracted after averaging
		gain_t gain_step;     // error to step shift
		gain_t gain_ramp;     // step to ramp shift
		err_t const_step;     // open loop step
		logic fb_on;          // closes the loop
	} loop_cfg_t;

endpackage

//--- logic/mod_gen.sv
`timescale 1ns/1ps

module mod_gen
	import fog_cfg_pkg::*, fog_sig_pkg::*;
(
	input  logic      CLOCK_DAC_1,
	input  logic      i_rst,
	input  loop_cfg_t i_cfg,
	output mod_evt_t  o_mod,
	output dac_t      o_level
);

	cfg_word_t half_cnt; // clocks left in the current half
	logic level_hi;      // even half, amp_h selected
	logic sw_pulse;      // registered half change

	// down counter reloads on zero, so each half lasts freq_cnt clocks
	// first half after reset is the high one and gets no switch pulse
	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			half_cnt <= i_cfg.freq_cnt - 1'b1;
			level_hi <= 1'b1;
			sw_pulse <= 1'b0;
		end else if (half_cnt == '0) begin
			half_cnt <= i_cfg.freq_cnt - 1'b1; // reload for the next half
			level_hi <= ~level_hi;             // square wave toggle
			sw_pulse <= 1'b1;                  // lands on offset 0 of new half
		end else begin
			half_cnt <= half_cnt - 1'b1;
			sw_pulse <= 1'b0;
		end
	end

	// timing to the demodulator
	assign o_mod = '{level_high: level_hi, switch_pulse: sw_pulse};

	// modulation level for the dac sum, registered there
	assign o_level = level_hi ? i_cfg.amp_h : i_cfg.amp_l;

endmodule

//--- logic/err_demod.sv
`timescale 1ns/1ps

module err_demod
	import fog_cfg_pkg::*, fog_sig_pkg::*;
(
	input  logic      CLOCK_DAC_1,
	input  logic      i_rst,
	input  loop_cfg_t i_cfg,
	input  mod_evt_t  i_mod,
	input  adc_t      i_adc,
	output err_evt_t  o_err
);

	adc_t adc_q;              // input register, one clock behind i_adc
	logic lvl_q;              // half level of the sample in adc_q
	cfg_word_t j_q;           // offset of adc_q inside its half
	cfg_word_t j_nxt;         // offset of the next sample
	cfg_word_t win_end;       // first offset past the window
	demod_state_t st, st_nxt; // what happens to adc_q this clock
	err_t sum_hi, sum_lo;     // window sums per half
	err_t diff, avg, err_nxt;
	err_t err_q;
	logic err_vld;
	logic pair_done;          // low half finished, back to high

	assign win_end   = i_cfg.wait_cnt + (cfg_word_t'(1) << i_cfg.avg_sel);
	assign pair_done = i_mod.switch_pulse & i_mod.level_high;

	// the switch pulse arrives while adc_q still holds the last sample
	// of the old half, so the next clock sees offset 0
	always_comb begin
		j_nxt  = i_mod.switch_pulse ? '0 : j_q + 1'b1;
		st_nxt = i_mod.switch_pulse ? S_SETTLE : st;
		case (st_nxt)
			S_SETTLE: if (j_nxt == i_cfg.wait_cnt) st_nxt = S_ACCUM;
			S_ACCUM:  if (j_nxt == win_end) st_nxt = S_HOLD;
			default:  st_nxt = S_HOLD; // idle until next switch
		endcase
	end

	// high minus low, averaged, then sign and offset
	always_comb begin
		diff    = sum_hi - sum_lo;
		avg     = diff >>> i_cfg.avg_sel; // arithmetic, keeps sign
		err_nxt = (i_cfg.polarity ? -avg : avg) - i_cfg.err_offset;
	end

	// sample path, not reset
	always_ff @(posedge CLOCK_DAC_1) begin
		adc_q <= i_adc;
		if (pair_done)
			err_q <= err_nxt;
	end

	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			st      <= S_SETTLE; // reset clock holds a stale sample
			j_q     <= '1;       // so the first clock after reset is offset 0
			lvl_q   <= 1'b1;
			sum_hi  <= '0;
			sum_lo  <= '0;
			err_vld <= 1'b0;
		end else begin
			st      <= st_nxt;
			j_q     <= j_nxt;
			lvl_q   <= i_mod.level_high; // aligns with adc_q
			err_vld <= pair_done;        // one clock pulse
			if (pair_done) begin
				// fresh pair starts
				sum_hi <= '0;
				sum_lo <= '0;
			end else if (st == S_ACCUM) begin
				if (lvl_q)
					sum_hi <= sum_hi + adc_q; // sign extended
				else
					sum_lo <= sum_lo + adc_q;
			end
		end
	end

	assign o_err = '{valid: err_vld, err: err_q};

endmodule

//--- logic/fb_step_acc.sv
`timescale 1ns/1ps

module fb_step_acc
	import fog_cfg_pkg::*, fog_sig_pkg::*;
(
	input  logic      CLOCK_DAC_1,
	input  logic      i_rst,
	input  loop_cfg_t i_cfg,
	input  err_evt_t  i_err,
	output step_evt_t o_step
);

	err_t step_q;    // current feedback step
	err_t err_shr;   // gain scaled error
	err_t step_nxt;
	logic step_vld;

	// integrator in closed loop, fixed step in open loop
	assign err_shr  = i_err.err >>> i_cfg.gain_step;
	assign step_nxt = i_cfg.fb_on ? step_q + err_shr : i_cfg.const_step;

	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			step_q   <= '0;
			step_vld <= 1'b0;
		end else begin
			step_vld <= i_err.valid; // one clock after the error
			if (i_err.valid)
				step_q <= step_nxt;
		end
	end

	assign o_step = '{valid: step_vld, step: step_q};

endmodule

//--- logic/phase_ramp_gen.sv
`timescale 1ns/1ps

module phase_ramp_gen
	import fog_cfg_pkg::*, fog_sig_pkg::*;
(
	input  logic      CLOCK_DAC_1,
	input  logic      i_rst,
	input  loop_cfg_t i_cfg,
	input  step_evt_t i_step,
	input  dac_t      i_level,
	output dac_t      o_dac
);

	dac_t ramp_q;   // serrodyne phase ramp
	err_t step_shr; // step scaled to ramp units
	dac_t dac_q;

	assign step_shr = i_step.step >>> i_cfg.gain_ramp;

	// one ramp increment per modulation period
	// overflow past 2^16 is the 2 pi reset of the ramp
	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			ramp_q <= '0;
		end else if (i_step.valid) begin
			ramp_q <= ramp_q + step_shr[DAC_W-1:0]; // low bits only, wraps
		end
	end

	// dac word every clock, square wave riding on the ramp
	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst)
			dac_q <= '0;
		else
			dac_q <= ramp_q + i_level; // mod 2^16
	end

	assign o_dac = dac_q;

endmodule

//--- logic/fog_loop_top.sv
`timescale 1ns/1ps

module fog_loop_top
	import fog_cfg_pkg::*, fog_sig_pkg::*;
(
	input  logic      CLOCK_DAC_1,
	input  logic      i_rst,
	input  loop_cfg_t i_cfg,   // static setup
	input  adc_t      i_adc,   // one sample per clock
	output dac_t      o_dac,   // to the phase modulator dac
	output err_evt_t  o_err,   // demodulated error
	output step_evt_t o_step   // feedback step
);

	mod_evt_t mod_evt; // half timing
	dac_t mod_level;   // amp_h or amp_l

	// square wave source
	mod_gen u_mod_gen (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst       (i_rst),
		.i_cfg       (i_cfg),
		.o_mod       (mod_evt),
		.o_level     (mod_level)
	);

	// error from the high and low window sums
	err_demod u_err_demod (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst       (i_rst),
		.i_cfg       (i_cfg),
		.i_mod       (mod_evt),
		.i_adc       (i_adc),
		.o_err       (o_err)
	);

	// loop integrator
	fb_step_acc u_fb_step_acc (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst       (i_rst),
		.i_cfg       (i_cfg),
		.i_err       (o_err),
		.o_step      (o_step)
	);

	// ramp plus modulation to the dac
	phase_ramp_gen u_phase_ramp_gen (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst       (i_rst),
		.i_cfg       (i_cfg),
		.i_step      (o_step),
		.i_level     (mod_level),
		.o_dac       (o_dac)
	);

endmodule

//--- sim/fog_loop_properties.sv
`timescale 1ns/1ps

module fog_loop_properties
	import fog_sig_pkg::*;
(
	input logic      CLOCK_DAC_1,
	input logic      i_rst,
	input mod_evt_t  i_mod,
	input err_evt_t  i_err,
	input step_evt_t i_step
);

	// step register loads on the clock after each error pulse
	a_step_after_err: assert property (@(posedge CLOCK_DAC_1) disable iff (i_rst)
		i_err.valid |=> i_step.valid)
		else $error("step valid missing one clock after error valid");

	a_step_has_err: assert property (@(posedge CLOCK_DAC_1) disable iff (i_rst)
		i_step.valid |-> $past(i_err.valid))
		else $error("step valid without an error valid one clock earlier");

	// pulses, never levels
	a_err_single: assert property (@(posedge CLOCK_DAC_1) disable iff (i_rst)
		i_err.valid |=> !i_err.valid)
		else $error("error valid held for two clocks");

	a_step_single: assert property (@(posedge CLOCK_DAC_1) disable iff (i_rst)
		i_step.valid |=> !i_step.valid)
		else $error("step valid held for two clocks");

	a_switch_single: assert property (@(posedge CLOCK_DAC_1) disable iff (i_rst)
		i_mod.switch_pulse |=> !i_mod.switch_pulse)
		else $error("switch pulse in consecutive clocks");

	// cleared once the first reset clock has passed
	a_quiet_in_reset: assert property (@(posedge CLOCK_DAC_1)
		(i_rst && $past(i_rst)) |-> !i_err.valid && !i_step.valid && !i_mod.switch_pulse)
		else $error("valid or switch pulse high during reset");

endmodule

bind fog_loop_top fog_loop_properties u_loop_props (
	.CLOCK_DAC_1 (CLOCK_DAC_1),
	.i_rst       (i_rst),
	.i_mod       (mod_evt),
	.i_err       (o_err),
	.i_step      (o_step)
);

//--- sim/tb_fog_loop.sv
`timescale 1ns/1ps

module tb_fog_loop
	import fog_cfg_pkg::*, fog_sig_pkg::*;
();

	localparam int CLK_PERIOD = 4;             // ns
	localparam int RST_CYCLES = 5;
	localparam logic [31:0] SEED = 32'd69;
	localparam int N_TESTS = 7;
	localparam int TAIL = 8;                   // clocks run past the last pair
	localparam int FREQ [N_TESTS]  = '{40, 64, 50, 32, 32, 32, 24}; // half periods
	localparam int PAIRS [N_TESTS] = '{3, 6, 12, 20, 20, 24, 10};

	logic CLOCK_DAC_1;
	logic i_rst;
	loop_cfg_t i_cfg;
	adc_t i_adc;
	dac_t o_dac;
	err_evt_t o_err;
	step_evt_t o_step;

	loop_cfg_t cfg;          // setup of the running test, for the model
	string tname;
	logic rand_mode;         // random samples, else one level per half
	adc_t lvl_hi, lvl_lo;
	logic [31:0] rng;
	int cyc;                 // k of the last edge, -1 in reset
	int errors, checks;
	err_t sum_hi, sum_lo;    // model window sums
	err_t step_ref;
	int pair;                // pairs completed by the model
	dac_t ramp_hist [64];    // ramp after each pair
	err_t exp_err[$], exp_step[$];
	int exp_err_cyc[$], exp_step_cyc[$];

	fog_loop_top i_dut (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst       (i_rst),
		.i_cfg       (i_cfg),
		.i_adc       (i_adc),
		.o_dac       (o_dac),
		.o_err       (o_err),
		.o_step      (o_step)
	);

	initial begin
		CLOCK_DAC_1 = 1'b0;
		forever #(CLK_PERIOD / 2) CLOCK_DAC_1 = ~CLOCK_DAC_1;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// window average of high minus low, then sign and offset
	function automatic err_t ref_err(input err_t s_hi, input err_t s_lo, input loop_cfg_t c);
		err_t d;
		d = (s_hi - s_lo) >>> c.avg_sel;
		if (c.polarity)
			d = -d;
		return d - c.err_offset;
	endfunction

	function automatic err_t ref_step(input err_t step, input err_t e, input loop_cfg_t c);
		if (!c.fb_on)
			return c.const_step; // open loop
		return step + (e >>> c.gain_step);
	endfunction

	function automatic dac_t ref_ramp(input dac_t ramp, input err_t step, input loop_cfg_t c);
		err_t inc;
		inc = step >>> c.gain_ramp;
		return ramp + inc[DAC_W-1:0]; // wraps at 2^16
	endfunction

	// adc value for cycle k
	function automatic adc_t next_sample(input int k);
		if (rand_mode) begin
			rng = xorshift(rng);
			return adc_t'(rng[ADC_W-1:0]);
		end
		return ((k / int'(cfg.freq_cnt)) % 2 == 0) ? lvl_hi : lvl_lo;
	endfunction

	task automatic check_err(input err_t got, input err_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_step(input err_t got, input err_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_dac(input dac_t got, input dac_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// feeds the model with the sample of cycle k
	task automatic log_sample(input int k, input adc_t s);
		int f, h, j;
		err_t e;
		f = int'(cfg.freq_cnt);
		h = k / f;
		j = k % f;
		if (j >= int'(cfg.wait_cnt) && j < int'(cfg.wait_cnt) + (1 << cfg.avg_sel)) begin
			if (h % 2 == 0)
				sum_hi = sum_hi + err_t'(s);
			else
				sum_lo = sum_lo + err_t'(s);
		end
		if (h % 2 == 1 && j == f - 1) begin // last clock of a low half
			e = ref_err(sum_hi, sum_lo, cfg);
			step_ref = ref_step(step_ref, e, cfg);
			pair++;
			ramp_hist[pair] = ref_ramp(ramp_hist[pair-1], step_ref, cfg);
			exp_err.push_back(e);
			exp_err_cyc.push_back(k + 1);  // visible after the switch edge
			exp_step.push_back(step_ref);
			exp_step_cyc.push_back(k + 2);
			sum_hi = '0;
			sum_lo = '0;
		end
	endtask

	task automatic setup_test(input int t);
		cfg = '0;
		cfg.freq_cnt = FREQ[t];
		cfg.amp_h = 16'h1800;
		cfg.amp_l = 16'he800;
		rand_mode = 1'b1;
		lvl_hi = '0;
		lvl_lo = '0;
		case (t)
			0: begin // flat ramp, dac shows the bare square wave
				tname = "reset_idle";
				cfg.wait_cnt = 4;
				cfg.avg_sel = 4;
				rand_mode = 1'b0;
				lvl_hi = 300;
				lvl_lo = -300;
			end
			1: begin
				tname = "open_loop";
				cfg.wait_cnt = 6;
				cfg.avg_sel = 5;
				cfg.const_step = 1234;
				cfg.gain_ramp = 2;
				rand_mode = 1'b0;
				lvl_hi = 1500;
				lvl_lo = -700;
			end
			2: begin // negative step wraps the ramp downwards
				tname = "polarity_offset";
				cfg.wait_cnt = 9;
				cfg.avg_sel = 3;
				cfg.polarity = 1'b1;
				cfg.err_offset = -37;
				cfg.const_step = -5000;
			end
			3: begin
				tname = "closed_gain0";
				cfg.wait_cnt = 3;
				cfg.avg_sel = 4;
				cfg.err_offset = 25;
				cfg.fb_on = 1'b1;
			end
			4: begin
				tname = "closed_gain3";
				cfg.wait_cnt = 5;
				cfg.avg_sel = 2;
				cfg.polarity = 1'b1;
				cfg.err_offset = -400; // drives the step upwards
				cfg.gain_step = 3;
				cfg.gain_ramp = 2;
				cfg.fb_on = 1'b1;
			end
			5: begin
				tname = "closed_gain9";
				cfg.wait_cnt = 2;
				cfg.avg_sel = 4;
				cfg.err_offset = 3000;
				cfg.gain_step = 9;
				cfg.gain_ramp = 6;
				cfg.fb_on = 1'b1;
			end
			default: begin // large step, ramp wraps every pair or two
				tname = "ramp_wrap";
				cfg.wait_cnt = 2;
				cfg.avg_sel = 3;
				cfg.const_step = 900000;
				cfg.gain_ramp = 4;
				cfg.amp_h = 16'h7000;
				cfg.amp_l = 16'h9000;
			end
		endcase
	endtask

	task automatic run_test(input int t);
		int k, last, err0, chk0;
		adc_t s;
		err0 = errors;
		chk0 = checks;
		setup_test(t);
		sum_hi = '0;
		sum_lo = '0;
		step_ref = '0;
		pair = 0;
		ramp_hist[0] = '0;
		exp_err.delete();
		exp_err_cyc.delete();
		exp_step.delete();
		exp_step_cyc.delete();
		@(posedge CLOCK_DAC_1);
		i_rst <= 1'b1;
		i_cfg <= cfg; // static from here on
		repeat (RST_CYCLES) @(posedge CLOCK_DAC_1);
		i_rst <= 1'b0;
		s = next_sample(0);
		i_adc <= s;
		log_sample(0, s);
		@(negedge CLOCK_DAC_1);
		check_dac(o_dac, '0, "dac word in reset");
		last = 2 * FREQ[t] * PAIRS[t] + TAIL;
		for (k = 0; k <= last; k++) begin
			@(posedge CLOCK_DAC_1);
			cyc = k;
			s = next_sample(k + 1); // seen by the dut at the next edge
			i_adc <= s;
			log_sample(k + 1, s);
		end
		cyc = -1;
		if (exp_err.size() != 0 || exp_step.size() != 0) begin
			$display("test %0d: %0d error and %0d step events never arrived",
				t, exp_err.size(), exp_step.size());
			errors++;
		end
		$display("test %0d %s: %0d checks, %0d errors", t, tname, checks - chk0, errors - err0);
	endtask

	// event and dac compare, half a clock after the edge
	always @(negedge CLOCK_DAC_1) begin
		int f, h;
		if (cyc >= 0) begin
			if (o_err.valid) begin
				if (exp_err.size() == 0) begin
					$display("unexpected error event at cycle %0d", cyc);
					errors++;
				end else begin
					if (exp_err_cyc[0] != cyc) begin
						$display("error event at cycle %0d, due at cycle %0d", cyc, exp_err_cyc[0]);
						errors++;
					end
					check_err(o_err.err, exp_err.pop_front(), "error word");
					void'(exp_err_cyc.pop_front());
				end
			end else if (exp_err_cyc.size() > 0 && cyc > exp_err_cyc[0]) begin
				$display("error event due at cycle %0d did not come", exp_err_cyc.pop_front());
				void'(exp_err.pop_front());
				errors++;
			end
			if (o_step.valid) begin
				if (exp_step.size() == 0) begin
					$display("unexpected step event at cycle %0d", cyc);
					errors++;
				end else begin
					if (exp_step_cyc[0] != cyc) begin
						$display("step event at cycle %0d, due at cycle %0d", cyc, exp_step_cyc[0]);
						errors++;
					end
					check_step(o_step.step, exp_step.pop_front(), "feedback step");
					void'(exp_step_cyc.pop_front());
				end
			end else if (exp_step_cyc.size() > 0 && cyc > exp_step_cyc[0]) begin
				$display("step event due at cycle %0d did not come", exp_step_cyc.pop_front());
				void'(exp_step.pop_front());
				errors++;
			end
			// whole first half, then mid half only
			f = int'(cfg.freq_cnt);
			h = cyc / f;
			if (cyc < f || cyc % f == f / 2)
				check_dac(o_dac, ramp_hist[h / 2] + ((h % 2 == 0) ? cfg.amp_h : cfg.amp_l),
					"dac word");
		end
	end

	function automatic longint watchdog_ns();
		longint total;
		int t;
		total = 0;
		for (t = 0; t < N_TESTS; t++)
			total += PAIRS[t] * 2 * FREQ[t] + 20;
		return total * 2 * CLK_PERIOD; // twice the expected run
	endfunction

	initial begin
		#(watchdog_ns());
		$display("watchdog expired before all tests finished");
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int t;
		i_rst = 1'b1;
		i_cfg = '0;
		i_adc = '0;
		cyc = -1;
		rng = SEED;
		errors = 0;
		checks = 0;
		for (t = 0; t < N_TESTS; t++)
			run_test(t);
		$display("%0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- tb.f
logic/fog_sig_pkg.sv
logic/fog_cfg_pkg.sv
logic/mod_gen.sv
logic/err_demod.sv
logic/fb_step_acc.sv
logic/phase_ramp_gen.sv
logic/fog_loop_top.sv
sim/fog_loop_properties.sv
sim/tb_fog_loop.sv

//--- run.sh
#!/bin/sh
# build and run the fog loop testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fog_loop -f tb.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_fog_loop)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Result: PASSED"; then
	exit 0
fi
exit 1
